/* hw/fizzle_pkg.sv */
// shared constants for the fizzlefade display, one clk_sys domain only
// raster geometry is fixed here and matched by the testbench

`default_nettype none

package fizzle_pkg;

    // raster: active area first, then blanking
    localparam int H_ACTIVE = 40;
    localparam int H_TOTAL  = 50;
    localparam int V_ACTIVE = 30;
    localparam int V_TOTAL  = 34;  // 50*34 = 1700 cycles per frame

    // framebuffer, painted top left of the active area
    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 12;
    localparam int FB_SCALE  = 2;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 192
    localparam int FB_ADDRW  = 8;

    localparam int CORDW = 6;   // unsigned coords
    localparam int CIDXW = 4;   // colour index
    localparam int CHANW = 4;   // one channel
    localparam int COLRW = 12;  // three channels

    localparam logic [COLRW-1:0] BG_COLR = 12'h137;

    // galois lfsr, maximal length: 255 states
    localparam int LFSR_LEN = 8;
    localparam logic [LFSR_LEN-1:0] LFSR_TAPS = 8'b1011_1000;

    // wishbone bus widths
    localparam int WB_ADRW = 5;
    localparam int WB_DATW = 16;

    // register map, word addresses
    typedef enum logic [WB_ADRW-1:0] {
        REG_CTRL     = 5'd0,   // [0] start, [7:4] fade colour
        REG_STATUS   = 5'd1,   // [0] busy, [1] done
        REG_RATE     = 5'd2,   // cycles per step minus one
        REG_WAIT     = 5'd3,   // frames before fading
        REG_PAL_BASE = 5'd16   // palette 16..31, write only
    } wb_reg_e;

    typedef enum logic [1:0] {
        FADE_IDLE,
        FADE_WAIT,
        FADE_RUN,
        FADE_DONE
    } fade_state_e;

endpackage

`default_nettype wire

/* hw/fb_port_if.sv */
// framebuffer write and read sides, no handshake
// read data arrives one cycle after the address

`default_nettype none
`timescale 1ns/1ps

interface fb_port_if;
    import fizzle_pkg::*;

    // write side, from the fade controller
    logic                fb_we;
    logic [FB_ADDRW-1:0] fb_addr_write;
    logic [CIDXW-1:0]    fb_colr_write;

    // read side
    logic [FB_ADDRW-1:0] fb_addr_read;   // from linebuffer
    logic [CIDXW-1:0]    fb_colr_read;   // from memory

    modport writer (output fb_we, fb_addr_write, fb_colr_write);
    modport reader (output fb_addr_read, input fb_colr_read);
    modport mem (
        input  fb_we, fb_addr_write, fb_colr_write, fb_addr_read,
        output fb_colr_read
    );

endinterface

`default_nettype wire

/* hw/display_timing.sv */
// reduced raster counters, no sync outputs
// strobes are decoded straight from the counters

`default_nettype none
`timescale 1ns/1ps

module display_timing (
    input  wire logic clk_sys,
    input  wire logic reset,
    output      logic [fizzle_pkg::CORDW-1:0] sx,  // horizontal position
    output      logic [fizzle_pkg::CORDW-1:0] sy,  // vertical position
    output      logic de,     // active area
    output      logic frame,  // first cycle of frame
    output      logic line    // first cycle of each line
);
    import fizzle_pkg::*;

    logic line_end;
    logic frame_end;

    always_comb begin
        line_end  = (sx == CORDW'(H_TOTAL-1));
        frame_end = line_end && (sy == CORDW'(V_TOTAL-1));
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (line_end) begin
                sx <= '0;
                // vertical steps once per line
                sy <= frame_end ? '0 : sy + 1'b1;
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    always_comb begin
        de    = (sx < CORDW'(H_ACTIVE)) && (sy < CORDW'(V_ACTIVE));
        line  = (sx == '0);
        frame = (sx == '0) && (sy == '0);
    end

endmodule

`default_nettype wire

/* hw/fb_ram.sv */
// simple dual-port framebuffer, starts as all index 0
// read during write returns old data

`default_nettype none
`timescale 1ns/1ps

module fb_ram (
    input wire logic clk_sys,
    fb_port_if.mem   fb
);
    import fizzle_pkg::*;

    logic [CIDXW-1:0] mem [FB_PIXELS];

    // power-up contents, no bitmap load
    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (fb.fb_we) begin
            mem[fb.fb_addr_write] <= fb.fb_colr_write;
        end
    end

    always_ff @(posedge clk_sys) begin
        fb.fb_colr_read <= mem[fb.fb_addr_read];  // one cycle latency
    end

endmodule

`default_nettype wire

/* hw/linebuffer.sv */
// double row buffer, one framebuffer row fetched per raster line
// output index is 0 outside the scaled paint area

`default_nettype none
`timescale 1ns/1ps

module linebuffer (
    input  wire logic clk_sys,
    input  wire logic reset,
    input  wire logic [fizzle_pkg::CORDW-1:0] sx,
    input  wire logic [fizzle_pkg::CORDW-1:0] sy,
    input  wire logic line,
    fb_port_if.reader fb,
    output      logic [fizzle_pkg::CIDXW-1:0] cidx
);
    import fizzle_pkg::*;

    localparam int LBW = $clog2(FB_WIDTH);  // row index width

    logic [CIDXW-1:0] store [2][FB_WIDTH];  // front and back rows
    logic             front;                // store shown this line
    logic             rd_sel;
    logic [CORDW-1:0] next_row;
    logic             fetch_en;
    logic             fetch_vld;            // read data valid next cycle
    logic [LBW-1:0]   fetch_idx;
    logic             paint;

    always_comb begin
        // row that the following raster line shows
        if (sy == CORDW'(V_TOTAL-1)) begin
            next_row = '0;  // wrap for line 0
        end else begin
            next_row = CORDW'((sy + 1'b1) / FB_SCALE);
        end
        fetch_en = (sx < CORDW'(FB_WIDTH)) && (next_row < CORDW'(FB_HEIGHT));
        fb.fb_addr_read = fetch_en ? FB_ADDRW'(next_row * FB_WIDTH + sx) : '0;
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            front     <= 1'b0;
            fetch_vld <= 1'b0;
        end else begin
            if (line) front <= ~front;  // swap at line start
            fetch_vld <= fetch_en;
        end
        fetch_idx <= sx[LBW-1:0];
    end

    // capture into back store, swap already done by now
    always_ff @(posedge clk_sys) begin
        if (fetch_vld) begin
            store[~front][fetch_idx] <= fb.fb_colr_read;
        end
    end

    always_comb begin
        rd_sel = line ? ~front : front;  // swap lands this cycle
        paint  = (sx < CORDW'(FB_WIDTH*FB_SCALE)) && (sy < CORDW'(FB_HEIGHT*FB_SCALE));
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cidx <= '0;
        end else begin
            cidx <= paint ? store[rd_sel][LBW'(sx / FB_SCALE)] : '0;
        end
    end

endmodule

`default_nettype wire

/* hw/clut.sv */
// 16-entry palette, host writes only
// all entries read black after reset

`default_nettype none
`timescale 1ns/1ps

module clut (
    input  wire logic clk_sys,
    input  wire logic reset,
    input  wire logic pal_we,
    input  wire logic [fizzle_pkg::CIDXW-1:0] pal_idx,
    input  wire logic [fizzle_pkg::COLRW-1:0] pal_colr,
    input  wire logic [fizzle_pkg::CIDXW-1:0] cidx,
    output      logic [fizzle_pkg::COLRW-1:0] colr
);
    import fizzle_pkg::*;

    localparam int PAL_SIZE = 1 << CIDXW;

    logic [COLRW-1:0] pal [PAL_SIZE];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < PAL_SIZE; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_we) begin
            pal[pal_idx] <= pal_colr;  // single cycle write
        end
    end

    // registered lookup
    always_ff @(posedge clk_sys) begin
        colr <= pal[cidx];
    end

endmodule

`default_nettype wire

/* hw/fizzle_ctrl.sv */
// wishbone classic slave plus fade engine
// one ack per access, palette and unmapped reads return 0

`default_nettype none
`timescale 1ns/1ps

module fizzle_ctrl (
    input  wire logic clk_sys,
    input  wire logic reset,
    input  wire logic frame,
    input  wire logic wb_cyc,
    input  wire logic wb_stb,
    input  wire logic wb_we,
    input  wire logic [fizzle_pkg::WB_ADRW-1:0] wb_adr,
    input  wire logic [fizzle_pkg::WB_DATW-1:0] wb_dat_w,
    output      logic [fizzle_pkg::WB_DATW-1:0] wb_dat_r,
    output      logic wb_ack,
    fb_port_if.writer fb,
    output      logic pal_we,
    output      logic [fizzle_pkg::CIDXW-1:0] pal_idx,
    output      logic [fizzle_pkg::COLRW-1:0] pal_colr
);
    import fizzle_pkg::*;

    localparam int LAST_STEP = 2**LFSR_LEN - 2;  // 255 steps in all

    fade_state_e         state;
    logic [WB_DATW-1:0]  rate_reg, wait_reg;
    logic [CIDXW-1:0]    fade_colr;
    logic [WB_DATW-1:0]  rate_cnt, wait_cnt;
    logic [LFSR_LEN-1:0] lfsr, lfsr_next;
    logic [LFSR_LEN-1:0] step_cnt;
    logic [FB_ADDRW-1:0] step_addr;
    logic                wb_acc, wb_wr, start;
    logic                busy, done;
    logic [WB_DATW-1:0]  rd_data;

    always_comb begin
        wb_acc = wb_cyc && wb_stb && !wb_ack;  // first cycle of access
        wb_wr  = wb_acc && wb_we;
        start  = wb_wr && (wb_adr == REG_CTRL) && wb_dat_w[0];
        busy   = (state == FADE_WAIT) || (state == FADE_RUN);
        done   = (state == FADE_DONE);
        lfsr_next = {1'b0, lfsr[LFSR_LEN-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
        step_addr = FB_ADDRW'(lfsr - 1'b1);  // states 1..255 map to 0..254
    end

    // register readback
    always_comb begin
        case (wb_adr)
            REG_CTRL:   rd_data = WB_DATW'({fade_colr, 4'b0000});
            REG_STATUS: rd_data = WB_DATW'({done, busy});
            REG_RATE:   rd_data = rate_reg;
            REG_WAIT:   rd_data = wait_reg;
            default:    rd_data = '0;  // palette and holes
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            pal_we    <= 1'b0;
            rate_reg  <= '0;
            wait_reg  <= '0;
            fade_colr <= '0;
        end else begin
            wb_ack <= wb_acc;  // one cycle after request
            pal_we <= wb_wr && (wb_adr >= REG_PAL_BASE);
            if (wb_wr) begin
                case (wb_adr)
                    REG_CTRL: fade_colr <= wb_dat_w[7:4];
                    REG_RATE: rate_reg  <= wb_dat_w;
                    REG_WAIT: wait_reg  <= wb_dat_w;
                    default:  ;  // others ignored here
                endcase
            end
        end
        if (wb_acc) wb_dat_r <= rd_data;  // held while ack high
        pal_idx  <= wb_adr[CIDXW-1:0];
        pal_colr <= wb_dat_w[COLRW-1:0];
    end

    // fade engine
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state    <= FADE_IDLE;
            lfsr     <= LFSR_LEN'(1);
            step_cnt <= '0;
            rate_cnt <= '0;
            wait_cnt <= '0;
            fb.fb_we <= 1'b0;
        end else begin
            fb.fb_we <= 1'b0;
            if (start) begin  // restart from any state
                state    <= FADE_WAIT;
                lfsr     <= LFSR_LEN'(1);
                step_cnt <= '0;
                rate_cnt <= '0;
                wait_cnt <= '0;
            end else begin
                case (state)
                    FADE_WAIT: begin
                        if (wait_cnt == wait_reg) state <= FADE_RUN;
                        else if (frame) wait_cnt <= wait_cnt + 1'b1;
                    end
                    FADE_RUN: begin
                        if (rate_cnt == rate_reg) begin
                            rate_cnt <= '0;
                            lfsr     <= lfsr_next;
                            step_cnt <= step_cnt + 1'b1;
                            fb.fb_we <= (step_addr < FB_ADDRW'(FB_PIXELS));  // skip off end
                            if (step_cnt == LFSR_LEN'(LAST_STEP)) state <= FADE_DONE;
                        end else begin
                            rate_cnt <= rate_cnt + 1'b1;
                        end
                    end
                    default: ;  // idle and done hold
                endcase
            end
        end
        fb.fb_addr_write <= step_addr;
        fb.fb_colr_write <= fade_colr;
    end

endmodule

`default_nettype wire

/* hw/fizzle_top.sv */
// top level, single clock; wishbone setup and 8-bit video out
// coords are delayed so colour and position match each cycle

`default_nettype none
`timescale 1ns/1ps

module fizzle_top (
    input  wire logic clk_sys,
    input  wire logic reset,
    input  wire logic wb_cyc,
    input  wire logic wb_stb,
    input  wire logic wb_we,
    input  wire logic [fizzle_pkg::WB_ADRW-1:0] wb_adr,
    input  wire logic [fizzle_pkg::WB_DATW-1:0] wb_dat_w,
    output      logic [fizzle_pkg::WB_DATW-1:0] wb_dat_r,
    output      logic wb_ack,
    output      logic [fizzle_pkg::CORDW-1:0] vid_sx,
    output      logic [fizzle_pkg::CORDW-1:0] vid_sy,
    output      logic vid_de,
    output      logic vid_frame,
    output      logic [7:0] vid_r,
    output      logic [7:0] vid_g,
    output      logic [7:0] vid_b
);
    import fizzle_pkg::*;

    localparam int POSW = 2*CORDW + 2;  // {frame, de, sy, sx}

    logic [CORDW-1:0] sx, sy;
    logic             de, frame, line;
    logic [CIDXW-1:0] lb_cidx;
    logic [COLRW-1:0] fb_colr;
    logic             pal_we;
    logic [CIDXW-1:0] pal_idx;
    logic [COLRW-1:0] pal_colr;
    logic [POSW-1:0]  pos_q [3];  // lb, clut, output stages
    logic [CORDW-1:0] sel_sx, sel_sy;
    logic             sel_de, paint;
    logic [COLRW-1:0] disp_colr;

    fb_port_if fb_port ();

    display_timing display_inst (.clk_sys, .reset, .sx, .sy, .de, .frame, .line);

    fb_ram fb_ram_inst (.clk_sys, .fb(fb_port.mem));

    linebuffer lb_inst (
        .clk_sys, .reset, .sx, .sy, .line, .fb(fb_port.reader), .cidx(lb_cidx)
    );

    clut clut_inst (
        .clk_sys, .reset, .pal_we, .pal_idx, .pal_colr, .cidx(lb_cidx), .colr(fb_colr)
    );

    fizzle_ctrl ctrl_inst (
        .clk_sys, .reset, .frame,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .fb(fb_port.writer),
        .pal_we, .pal_idx, .pal_colr
    );

    // position pipeline, 3 deep
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) pos_q[i] <= '0;
        end else begin
            pos_q[0] <= {frame, de, sy, sx};
            pos_q[1] <= pos_q[0];
            pos_q[2] <= pos_q[1];
        end
    end

    // clut colour lines up with stage 1
    always_comb begin
        {sel_de, sel_sy, sel_sx} = pos_q[1][POSW-2:0];
        paint = (sel_sx < CORDW'(FB_WIDTH*FB_SCALE)) && (sel_sy < CORDW'(FB_HEIGHT*FB_SCALE));
        if (!sel_de) disp_colr = '0;              // blanking
        else if (paint) disp_colr = fb_colr;
        else disp_colr = BG_COLR;
    end

    // widen each channel by repeating the nibble
    always_ff @(posedge clk_sys) begin
        vid_r <= {2{disp_colr[3*CHANW-1:2*CHANW]}};
        vid_g <= {2{disp_colr[2*CHANW-1:CHANW]}};
        vid_b <= {2{disp_colr[CHANW-1:0]}};
    end

    assign {vid_frame, vid_de, vid_sy, vid_sx} = pos_q[2];

endmodule

`default_nettype wire

/* bench/tb_fizzle.sv */
// directed testbench for fizzle_top, single clock, inputs driven on the falling edge
// palette colours come from a fixed seed; expected pixels come from the tb's own model

`default_nettype none
`timescale 1ns/1ps

module tb_fizzle;
    import fizzle_pkg::*;

    localparam int ACK_TIMEOUT   = 20;
    localparam int FRAME_TIMEOUT = 4000;
    localparam int POLL_LIMIT    = 1000;  // status reads before giving up
    localparam int PAINT_W       = FB_WIDTH * FB_SCALE;
    localparam int PAINT_H       = FB_HEIGHT * FB_SCALE;
    localparam logic [CIDXW-1:0] FADE_IDX = 4'd9;

    logic               clk_sys;
    logic               reset;
    logic               wb_cyc, wb_stb, wb_we;
    logic [WB_ADRW-1:0] wb_adr;
    logic [WB_DATW-1:0] wb_dat_w;
    logic [WB_DATW-1:0] wb_dat_r;
    logic               wb_ack;
    logic [CORDW-1:0]   vid_sx, vid_sy;
    logic               vid_de, vid_frame;
    logic [7:0]         vid_r, vid_g, vid_b;

    // reference model state
    logic [COLRW-1:0] pal_model [1 << CIDXW];
    logic [CIDXW-1:0] fb_model [FB_PIXELS];
    logic [COLRW-1:0] cap_colr [V_TOTAL][H_TOTAL];  // one captured frame
    int               cap_len, cap_de;

    integer seed = 3434;
    string  cur_test;
    int     errors, err_mark, n_tests, n_failed;

    fizzle_top i_dut (
        .clk_sys, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .vid_sx, .vid_sy, .vid_de, .vid_frame, .vid_r, .vid_g, .vid_b
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;  // 8 ns
    end

    task automatic check_colr(input string what, input logic [COLRW-1:0] exp,
                              input logic [COLRW-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s: %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [WB_DATW-1:0] exp,
                              input logic [WB_DATW-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s: %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("** Error: %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // one classic cycle; master drops stb once ack is seen
    task automatic wb_access(input logic we, input logic [WB_ADRW-1:0] adr,
                             input logic [WB_DATW-1:0] wdat,
                             output logic [WB_DATW-1:0] rdat);
        int waited;
        int acks;
        waited = 0;
        acks   = 0;
        rdat   = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge clk_sys);
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        if (wb_ack) begin
            acks = 1;
            rdat = wb_dat_r;  // valid with ack
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (acks == 0) begin
            $display("%s: no ack within %0d cycles at address %0d", cur_test, ACK_TIMEOUT, adr);
            errors++;
        end else begin
            repeat (3) begin  // watch for a stray second ack
                @(negedge clk_sys);
                if (wb_ack) acks++;
            end
            check_count("acks per access", 1, acks);
        end
    endtask

    task automatic wb_write(input logic [WB_ADRW-1:0] adr, input logic [WB_DATW-1:0] dat);
        logic [WB_DATW-1:0] rd_ignore;
        wb_access(1'b1, adr, dat, rd_ignore);
    endtask

    task automatic wb_read(input logic [WB_ADRW-1:0] adr, output logic [WB_DATW-1:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    // wait for vid_frame, then record until the next one
    task automatic capture_frame();
        int waited;
        int n;
        int bad_pos;
        int bad_wide;
        waited   = 0;
        n        = 0;
        bad_pos  = 0;
        bad_wide = 0;
        cap_de   = 0;
        cap_len  = 0;
        @(negedge clk_sys);
        while (!vid_frame && waited < FRAME_TIMEOUT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (!vid_frame) begin
            $display("%s: no vid_frame pulse within %0d cycles", cur_test, FRAME_TIMEOUT);
            errors++;
            return;
        end
        do begin
            if (n < H_TOTAL * V_TOTAL) begin
                if (vid_sx != CORDW'(n % H_TOTAL) || vid_sy != CORDW'(n / H_TOTAL)) bad_pos++;
                else cap_colr[vid_sy][vid_sx] = {vid_r[7:4], vid_g[7:4], vid_b[7:4]};
            end
            if (vid_r[3:0] != vid_r[7:4] || vid_g[3:0] != vid_g[7:4]
                    || vid_b[3:0] != vid_b[7:4]) bad_wide++;
            if (vid_de) cap_de++;
            n++;
            @(negedge clk_sys);
        end while (!vid_frame && n < FRAME_TIMEOUT);
        cap_len = n;
        check_count("raster order errors", 0, bad_pos);
        check_count("channel widening errors", 0, bad_wide);
    endtask

    // black in blanking, palette in paint area, background elsewhere
    function automatic logic [COLRW-1:0] expect_colr(input int x, input int y);
        if (x >= H_ACTIVE || y >= V_ACTIVE) return '0;
        if (x < PAINT_W && y < PAINT_H)
            return pal_model[fb_model[(y / FB_SCALE) * FB_WIDTH + x / FB_SCALE]];
        return BG_COLR;
    endfunction

    task automatic compare_frame();
        if (cap_len == 0) return;  // capture already reported
        for (int y = 0; y < V_TOTAL; y++) begin
            for (int x = 0; x < H_TOTAL; x++) begin
                check_colr($sformatf("pixel %0d,%0d", x, y), expect_colr(x, y), cap_colr[y][x]);
            end
        end
    endtask

    // paint area during a fade holds only entries 0 and 9
    task automatic scan_fade(output int n_fade);
        n_fade = 0;
        for (int y = 0; y < PAINT_H; y++) begin
            for (int x = 0; x < PAINT_W; x++) begin
                if (cap_colr[y][x] === pal_model[FADE_IDX]) n_fade++;
                else check_colr($sformatf("pixel %0d,%0d", x, y), pal_model[0], cap_colr[y][x]);
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = errors;
        n_tests++;
    endtask

    task automatic end_test();
        if (errors > err_mark) begin
            n_failed++;
            $display("test %s: FAIL with %0d errors", cur_test, errors - err_mark);
        end else begin
            $display("test %s: ok", cur_test);
        end
    endtask

    task automatic test_timing();
        start_test("timing");
        capture_frame();
        check_count("cycles per frame", H_TOTAL * V_TOTAL, cap_len);
        check_count("de cycles per frame", H_ACTIVE * V_ACTIVE, cap_de);
        end_test();
    endtask

    task automatic test_regions();
        start_test("regions");
        for (int i = 0; i < (1 << CIDXW); i++) begin
            pal_model[i] = COLRW'($random(seed));
        end
        if (pal_model[FADE_IDX] == pal_model[0]) pal_model[FADE_IDX] = ~pal_model[0];
        for (int i = 0; i < (1 << CIDXW); i++) begin
            wb_write(WB_ADRW'(REG_PAL_BASE + i), WB_DATW'(pal_model[i]));
        end
        for (int a = 0; a < FB_PIXELS; a++) fb_model[a] = '0;  // power-up contents
        capture_frame();
        compare_frame();
        end_test();
    endtask

    task automatic test_registers();
        logic [WB_DATW-1:0] rd;
        start_test("registers");
        wb_read(REG_STATUS, rd);
        check_word("status after reset", 16'h0000, rd);
        wb_write(REG_RATE, 16'h1234);
        wb_read(REG_RATE, rd);
        check_word("rate readback", 16'h1234, rd);
        wb_write(REG_WAIT, 16'h0042);
        wb_read(REG_WAIT, rd);
        check_word("wait readback", 16'h0042, rd);
        wb_read(5'd7, rd);                           // hole in the map
        check_word("unmapped read", 16'h0000, rd);
        wb_read(WB_ADRW'(REG_PAL_BASE + 2), rd);     // palette is write only
        check_word("palette read", 16'h0000, rd);
        end_test();
    endtask

    task automatic test_fade_progress();
        logic [WB_DATW-1:0] rd;
        int n_fade;
        int prev_fade;
        int frames;
        prev_fade = 0;
        frames    = 0;
        start_test("fade progress");
        wb_write(REG_RATE, 16'd3);
        wb_write(REG_WAIT, 16'd1);
        wb_write(REG_CTRL, WB_DATW'({FADE_IDX, 4'b0001}));  // colour 9 plus start
        wb_read(REG_STATUS, rd);
        check_word("status after start", 16'h0001, rd);
        do begin
            capture_frame();
            if (cap_len != 0) begin
                scan_fade(n_fade);
                if (n_fade < prev_fade) begin
                    $display("%s: fade pixel count fell from %0d to %0d",
                             cur_test, prev_fade, n_fade);
                    errors++;
                end
                prev_fade = n_fade;
            end
            frames++;
            wb_read(REG_STATUS, rd);
        end while ((rd[0] || frames < 2) && frames < 4);  // fade fits in one frame
        end_test();
    endtask

    task automatic test_fade_done();
        logic [WB_DATW-1:0] rd;
        int polls;
        polls = 0;
        start_test("fade completion");
        do begin
            wb_read(REG_STATUS, rd);
            polls++;
        end while (rd[1:0] != 2'b10 && polls < POLL_LIMIT);
        check_word("status when done", 16'h0002, rd);
        for (int a = 0; a < FB_PIXELS; a++) fb_model[a] = FADE_IDX;  // lfsr covers 0..254
        capture_frame();
        compare_frame();
        end_test();
    endtask

    task automatic test_palette_update();
        start_test("palette update");
        pal_model[FADE_IDX] = ~pal_model[FADE_IDX];
        wb_write(WB_ADRW'(REG_PAL_BASE + FADE_IDX), WB_DATW'(pal_model[FADE_IDX]));
        capture_frame();
        compare_frame();  // bg and blanking must not move
        end_test();
    endtask

    initial begin
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        errors   = 0;
        n_tests  = 0;
        n_failed = 0;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;

        test_timing();
        test_regions();
        test_registers();
        test_fade_progress();
        test_fade_done();
        test_palette_update();

        $display("tests %0d, failed tests %0d, failed checks %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/fizzle_pkg.sv
hw/fb_port_if.sv
hw/display_timing.sv
hw/fb_ram.sv
hw/linebuffer.sv
hw/clut.sv
hw/fizzle_ctrl.sv
hw/fizzle_top.sv
bench/tb_fizzle.sv

/* run_sim.sh */
#!/bin/sh
# builds tb_fizzle with verilator and runs it; pass is decided from the run log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_fizzle -f src.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_fizzle > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -q "^Result: PASSED$" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $SIM_LOG"
    exit 1
fi
